// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    // funct3 values shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // One instruction word, five views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    // ADDI x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;
    localparam logic [31:0] RESET_PC  = 32'h0000_0000;

endpackage

// ==== rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    typedef enum logic [1:0] {
        REGFILE,
        FROM_MEM,
        FROM_WB
    } fwd_sel_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } if_id_t;

    typedef struct packed {
        logic [31:0]         pc;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [4:0]          rd;
        logic [31:0]         rs1_val;
        logic [31:0]         rs2_val;
        logic [31:0]         imm;
        rv_isa_pkg::alu_op_e alu_op;
        logic                use_imm;
        logic                is_load;
        logic                is_store;
        logic                is_branch;
        logic                branch_ne;
        logic                is_jal;
        logic                reg_we;
        logic                valid;
    } id_ex_t;

    // result carries the ALU value, the load/store address or the link address
    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] result;
        logic [31:0] store_data;
        logic        is_load;
        logic        is_store;
        logic        reg_we;
        logic        valid;
    } ex_mem_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] wb_value;
        logic        reg_we;
    } mem_wb_t;

endpackage

// ==== rv_regfile.sv ====
module rv_regfile (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_we,
    input  logic [4:0]  i_waddr,
    input  logic [31:0] i_wdata,
    input  logic [4:0]  i_raddr1,
    input  logic [4:0]  i_raddr2,
    output logic [31:0] o_rdata1,
    output logic [31:0] o_rdata2
);

    logic [31:0] regs [1:31];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != 5'd0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // Write-through so decode sees the value being written back
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        return (i_we && i_waddr == addr) ? i_wdata : regs[addr];
    endfunction

    always_comb begin
        o_rdata1 = read_port(i_raddr1);
        o_rdata2 = read_port(i_raddr2);
    end

endmodule

// ==== rv_fetch.sv ====
module rv_fetch (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_freeze,
    input  logic                i_stall,
    input  logic                i_flush,
    input  logic                i_taken,
    input  logic [31:0]         i_target,
    input  logic [31:0]         i_instr,
    output logic [31:0]         o_pc,
    output rv_pipe_pkg::if_id_t o_if_id
);
    import rv_isa_pkg::*;

    logic [31:0] pc_next;

    assign pc_next = i_taken ? i_target : (i_stall ? o_pc : o_pc + 32'd4);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc <= RESET_PC;
        end else if (!i_freeze) begin
            o_pc <= pc_next;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_if_id.pc    <= RESET_PC;
            o_if_id.instr <= NOP_INSTR;
        end else if (!i_freeze) begin
            if (i_flush) begin
                // Word fetched behind a taken branch is dropped
                o_if_id.instr <= NOP_INSTR;
            end else if (!i_stall) begin
                o_if_id.pc    <= o_pc;
                o_if_id.instr <= i_instr;
            end
        end
    end

    // Jump targets from execute must keep the PC on a word boundary
    assert property (@(posedge i_clk) disable iff (!i_rst_n) o_pc[1:0] == 2'b00)
        else $error("PC not word aligned: %h", o_pc);

endmodule

// ==== rv_decode.sv ====
module rv_decode (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_freeze,
    input  logic                 i_stall,
    input  logic                 i_flush,
    input  rv_pipe_pkg::if_id_t  i_if_id,
    input  rv_pipe_pkg::mem_wb_t i_mem_wb,
    output logic [4:0]           o_rs1,
    output logic [4:0]           o_rs2,
    output rv_pipe_pkg::id_ex_t  o_id_ex
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    instr_u      ir;
    opcode_e     opcode;
    logic [2:0]  funct3;
    logic        uses_rs2;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] imm_i;
    id_ex_t      id_next;

    assign ir     = i_if_id.instr;
    assign opcode = ir.r_fmt.opcode;
    assign funct3 = ir.r_fmt.funct3;

    // Unused source fields read as x0 so they never cause a stall
    assign uses_rs2 = (opcode == OP) || (opcode == STORE) || (opcode == BRANCH);
    assign o_rs1    = (opcode != JAL) ? ir.r_fmt.rs1 : 5'd0;
    assign o_rs2    = uses_rs2 ? ir.r_fmt.rs2 : 5'd0;
    assign imm_i    = {{20{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};

    rv_regfile regfile_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_we     (i_mem_wb.reg_we),
        .i_waddr  (i_mem_wb.rd),
        .i_wdata  (i_mem_wb.wb_value),
        .i_raddr1 (o_rs1),
        .i_raddr2 (o_rs2),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic sub);
        case (f3)
            F3_ADD:  return sub ? SUB : ADD;
            F3_SLT:  return SLT;
            F3_XOR:  return XOR;
            F3_OR:   return OR;
            F3_AND:  return AND;
            default: return ADD;
        endcase
    endfunction

    always_comb begin
        id_next         = '0;
        id_next.pc      = i_if_id.pc;
        id_next.rs1     = o_rs1;
        id_next.rs2     = o_rs2;
        id_next.rd      = ir.r_fmt.rd;
        id_next.rs1_val = rdata1;
        id_next.rs2_val = rdata2;
        id_next.alu_op  = ADD;
        id_next.valid   = 1'b1;
        case (opcode)
            OP: begin
                id_next.alu_op = alu_decode(funct3, ir.r_fmt.funct7 == F7_SUB);
                id_next.reg_we = 1'b1;
            end
            OP_IMM: begin
                id_next.alu_op  = alu_decode(funct3, 1'b0);
                id_next.imm     = imm_i;
                id_next.use_imm = 1'b1;
                id_next.reg_we  = 1'b1;
            end
            LOAD: begin
                id_next.imm     = imm_i;
                id_next.use_imm = 1'b1;
                id_next.is_load = 1'b1;
                id_next.reg_we  = 1'b1;
            end
            STORE: begin
                id_next.imm      = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
                id_next.use_imm  = 1'b1;
                id_next.is_store = 1'b1;
            end
            BRANCH: begin
                id_next.imm       = {{19{ir.b_fmt.imm_12}}, ir.b_fmt.imm_12, ir.b_fmt.imm_11,
                                     ir.b_fmt.imm_10_5, ir.b_fmt.imm_4_1, 1'b0};
                id_next.is_branch = 1'b1;
                id_next.branch_ne = (funct3 == F3_BNE);
            end
            JAL: begin
                id_next.imm    = {{11{ir.j_fmt.imm_20}}, ir.j_fmt.imm_20, ir.j_fmt.imm_19_12,
                                  ir.j_fmt.imm_11, ir.j_fmt.imm_10_1, 1'b0};
                id_next.is_jal = 1'b1;
                id_next.reg_we = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_id_ex <= '0;
        end else if (!i_freeze) begin
            if (i_stall || i_flush) begin
                o_id_ex <= '0;
            end else begin
                o_id_ex <= id_next;
            end
        end
    end

endmodule

// ==== rv_execute.sv ====
module rv_execute (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_freeze,
    input  rv_pipe_pkg::id_ex_t   i_id_ex,
    input  rv_pipe_pkg::fwd_sel_e i_fwd_a,
    input  rv_pipe_pkg::fwd_sel_e i_fwd_b,
    input  logic [31:0]           i_mem_value,
    input  rv_pipe_pkg::mem_wb_t  i_mem_wb,
    output logic                  o_taken,
    output logic [31:0]           o_target,
    output rv_pipe_pkg::ex_mem_t  o_ex_mem
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_b;
    logic [31:0] alu_y;
    logic [31:0] pc_plus4;

    // i_mem_value already holds loaded data for a load in MEM
    function automatic logic [31:0] operand(input fwd_sel_e sel, input logic [31:0] reg_val);
        case (sel)
            FROM_MEM: return i_mem_value;
            FROM_WB:  return i_mem_wb.wb_value;
            default:  return reg_val;
        endcase
    endfunction

    always_comb begin
        op_a = operand(i_fwd_a, i_id_ex.rs1_val);
        op_b = operand(i_fwd_b, i_id_ex.rs2_val);
    end

    assign alu_b = i_id_ex.use_imm ? i_id_ex.imm : op_b;

    always_comb begin
        case (i_id_ex.alu_op)
            SUB:     alu_y = op_a - alu_b;
            AND:     alu_y = op_a & alu_b;
            OR:      alu_y = op_a | alu_b;
            XOR:     alu_y = op_a ^ alu_b;
            SLT:     alu_y = {31'd0, $signed(op_a) < $signed(alu_b)};
            default: alu_y = op_a + alu_b;
        endcase
    end

    assign pc_plus4 = i_id_ex.pc + 32'd4;
    assign o_target = i_id_ex.pc + i_id_ex.imm;

    // BNE inverts the equality test
    assign o_taken = i_id_ex.valid && (i_id_ex.is_jal ||
                     (i_id_ex.is_branch && ((op_a == op_b) != i_id_ex.branch_ne)));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ex_mem <= '0;
        end else if (!i_freeze) begin
            o_ex_mem.rd         <= i_id_ex.rd;
            o_ex_mem.result     <= i_id_ex.is_jal ? pc_plus4 : alu_y;
            o_ex_mem.store_data <= op_b;
            o_ex_mem.is_load    <= i_id_ex.is_load;
            o_ex_mem.is_store   <= i_id_ex.is_store;
            o_ex_mem.reg_we     <= i_id_ex.reg_we;
            o_ex_mem.valid      <= i_id_ex.valid;
        end
    end

endmodule

// ==== rv_mem_wb.sv ====
module rv_mem_wb (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_freeze,
    input  rv_pipe_pkg::ex_mem_t i_ex_mem,
    input  logic [31:0]          i_ddt,
    input  logic                 i_ackd_n,
    output logic [31:0]          o_dad,
    output logic [31:0]          o_ddt,
    output logic                 o_mreq,
    output logic                 o_write,
    output logic [31:0]          o_mem_value,
    output rv_pipe_pkg::mem_wb_t o_mem_wb
);

    logic        acc_done;
    logic        acc_fire;
    logic [31:0] load_hold;

    // A finished access stays quiet while fetch still holds the pipeline
    assign o_mreq   = i_ex_mem.valid && (i_ex_mem.is_load || i_ex_mem.is_store) && !acc_done;
    assign o_write  = i_ex_mem.valid && i_ex_mem.is_store && !acc_done;
    assign o_dad    = i_ex_mem.result;
    assign o_ddt    = i_ex_mem.store_data;
    assign acc_fire = o_mreq && !i_ackd_n;

    assign o_mem_value = !i_ex_mem.is_load ? i_ex_mem.result :
                         (acc_done ? load_hold : i_ddt);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc_done <= 1'b0;
        end else if (!i_freeze) begin
            acc_done <= 1'b0;
        end else if (acc_fire) begin
            acc_done <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (acc_fire) begin
            load_hold <= i_ddt;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem_wb <= '0;
        end else if (!i_freeze) begin
            o_mem_wb.rd       <= i_ex_mem.rd;
            o_mem_wb.wb_value <= o_mem_value;
            o_mem_wb.reg_we   <= i_ex_mem.valid && i_ex_mem.reg_we;
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n) o_write |-> o_mreq)
        else $error("Write strobe without memory request");

    // Request must hold still until the data memory acknowledges
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_mreq && i_ackd_n |=> o_mreq && $stable(o_dad) && $stable(o_ddt))
        else $error("Data request changed before acknowledge");

endmodule

// ==== rv_hazard.sv ====
module rv_hazard (
    input  logic [4:0]            i_id_rs1,
    input  logic [4:0]            i_id_rs2,
    input  rv_pipe_pkg::id_ex_t   i_id_ex,
    input  rv_pipe_pkg::ex_mem_t  i_ex_mem,
    input  rv_pipe_pkg::mem_wb_t  i_mem_wb,
    input  logic                  i_taken,
    input  logic                  i_acki_n,
    input  logic                  i_ackd_n,
    input  logic                  i_mreq,
    output rv_pipe_pkg::fwd_sel_e o_fwd_a,
    output rv_pipe_pkg::fwd_sel_e o_fwd_b,
    output logic                  o_stall,
    output logic                  o_flush,
    output logic                  o_freeze
);
    import rv_pipe_pkg::*;

    // Younger EX/MEM result wins over MEM/WB
    function automatic fwd_sel_e fwd_select(input logic [4:0] rs);
        if (rs == 5'd0) begin
            return REGFILE;
        end
        if (i_ex_mem.valid && i_ex_mem.reg_we && i_ex_mem.rd == rs) begin
            return FROM_MEM;
        end
        if (i_mem_wb.reg_we && i_mem_wb.rd == rs) begin
            return FROM_WB;
        end
        return REGFILE;
    endfunction

    always_comb begin
        o_fwd_a = fwd_select(i_id_ex.rs1);
        o_fwd_b = fwd_select(i_id_ex.rs2);
    end

    // Load in EX feeding the instruction in decode
    assign o_stall = i_id_ex.valid && i_id_ex.is_load && i_id_ex.rd != 5'd0 &&
                     (i_id_ex.rd == i_id_rs1 || i_id_ex.rd == i_id_rs2);

    assign o_flush  = i_taken;
    assign o_freeze = i_acki_n || (i_mreq && i_ackd_n);

    // EX holds either a load or a jump, never both
    always_comb begin
        assert (!(o_stall && o_flush) || o_freeze)
            else $error("Stall and flush raised together");
    end

endmodule

// ==== rv_core.sv ====
module rv_core (
    input  logic        clk,
    input  logic        i_rst_n,
    output logic [31:0] o_iad,
    input  logic [31:0] i_idt,
    input  logic        i_acki_n,
    output logic [31:0] o_dad,
    output logic [31:0] o_ddt,
    input  logic [31:0] i_ddt,
    output logic        o_mreq,
    output logic        o_write,
    input  logic        i_ackd_n
);
    import rv_pipe_pkg::*;

    if_id_t      if_id;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    mem_wb_t     mem_wb;
    fwd_sel_e    fwd_a;
    fwd_sel_e    fwd_b;
    logic [4:0]  id_rs1;
    logic [4:0]  id_rs2;
    logic        stall;
    logic        flush;
    logic        freeze;
    logic        taken;
    logic [31:0] target;
    logic [31:0] mem_value;

    rv_fetch fetch_i (
        .i_clk    (clk),
        .i_rst_n  (i_rst_n),
        .i_freeze (freeze),
        .i_stall  (stall),
        .i_flush  (flush),
        .i_taken  (taken),
        .i_target (target),
        .i_instr  (i_idt),
        .o_pc     (o_iad),
        .o_if_id  (if_id)
    );

    rv_decode decode_i (
        .i_clk    (clk),
        .i_rst_n  (i_rst_n),
        .i_freeze (freeze),
        .i_stall  (stall),
        .i_flush  (flush),
        .i_if_id  (if_id),
        .i_mem_wb (mem_wb),
        .o_rs1    (id_rs1),
        .o_rs2    (id_rs2),
        .o_id_ex  (id_ex)
    );

    rv_execute execute_i (
        .i_clk       (clk),
        .i_rst_n     (i_rst_n),
        .i_freeze    (freeze),
        .i_id_ex     (id_ex),
        .i_fwd_a     (fwd_a),
        .i_fwd_b     (fwd_b),
        .i_mem_value (mem_value),
        .i_mem_wb    (mem_wb),
        .o_taken     (taken),
        .o_target    (target),
        .o_ex_mem    (ex_mem)
    );

    rv_mem_wb mem_wb_i (
        .i_clk       (clk),
        .i_rst_n     (i_rst_n),
        .i_freeze    (freeze),
        .i_ex_mem    (ex_mem),
        .i_ddt       (i_ddt),
        .i_ackd_n    (i_ackd_n),
        .o_dad       (o_dad),
        .o_ddt       (o_ddt),
        .o_mreq      (o_mreq),
        .o_write     (o_write),
        .o_mem_value (mem_value),
        .o_mem_wb    (mem_wb)
    );

    rv_hazard hazard_i (
        .i_id_rs1 (id_rs1),
        .i_id_rs2 (id_rs2),
        .i_id_ex  (id_ex),
        .i_ex_mem (ex_mem),
        .i_mem_wb (mem_wb),
        .i_taken  (taken),
        .i_acki_n (i_acki_n),
        .i_ackd_n (i_ackd_n),
        .i_mreq   (o_mreq),
        .o_fwd_a  (fwd_a),
        .o_fwd_b  (fwd_b),
        .o_stall  (stall),
        .o_flush  (flush),
        .o_freeze (freeze)
    );

endmodule

// ==== tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int HALF_PERIOD = 4
) (
    output logic o_clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever begin
            #HALF_PERIOD o_clk = ~o_clk;
        end
    end

endmodule

// ==== tb_rv_core.sv ====
module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          PROG_LEN    = 38;
    localparam int          N_STORES    = 12;
    localparam int          DRIVE_DELAY = 1;
    localparam int          TAIL_CYCLES = 64;
    // 40 cycles per word, four-fold for wait states
    localparam int          CYCLE_LIMIT = PROG_LEN * 40 * 4;
    localparam logic [31:0] SEED        = 32'hdca557d8;
    localparam logic [31:0] NOP_WORD    = 32'h0000_0013;
    localparam int          OPI         = 'h13;
    localparam int          LD          = 'h03;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] iad;
    logic [31:0] idt;
    logic        acki_n;
    logic [31:0] dad;
    logic [31:0] ddt_out;
    logic [31:0] ddt_in;
    logic        mreq;
    logic        write;
    logic        ackd_n;

    logic [31:0] prog_table [64];
    store_t      store_table [N_STORES];
    logic [31:0] dmem [64];
    int          ifetch_waits [256];
    int          data_waits [256];
    logic [7:0]  ipick;
    logic [7:0]  dpick;
    int          iwait;
    int          dwait;
    bit          dactive;
    int          cycles;
    int          errors;
    int          checked;

    tb_clk_gen #(.HALF_PERIOD(4)) clk_gen_i (.o_clk(clk));

    rv_core rv_core_i (
        .clk      (clk),
        .i_rst_n  (rst_n),
        .o_iad    (iad),
        .i_idt    (idt),
        .i_acki_n (acki_n),
        .o_dad    (dad),
        .o_ddt    (ddt_out),
        .i_ddt    (ddt_in),
        .o_mreq   (mreq),
        .o_write  (write),
        .i_ackd_n (ackd_n)
    );

    // Instruction word assemblers
    function automatic logic [31:0] rtype(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input int opc, input int f3, input int rd,
                                          input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] stype(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input int f3, input int rs1, input int rs2,
                                          input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] jtype(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] instr_at(input logic [31:0] addr);
        if (addr[31:8] != 24'd0) begin
            return NOP_WORD;
        end
        return prog_table[addr[7:2]];
    endfunction

    task automatic check_idle(input string when_txt);
        if (mreq !== 1'b0 || write !== 1'b0) begin
            errors++;
            $display("ERR %0t: data request active %s, mreq=%b write=%b",
                     $time, when_txt, mreq, write);
        end
        if (iad !== 32'h0) begin
            errors++;
            $display("ERR %0t: fetch address %h %s, expected 0", $time, iad, when_txt);
        end
    endtask

    always @(posedge clk) begin
        cycles++;
    end

    // Fetch side, new wait count after each acknowledged word
    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (!acki_n) begin
            iwait = ifetch_waits[ipick];
            ipick = ipick + 8'd1;
        end
        if (iwait > 0) begin
            acki_n = 1'b1;
            iwait  = iwait - 1;
        end else begin
            acki_n = 1'b0;
            idt    = instr_at(iad);
        end
    end

    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (!mreq) begin
            ackd_n  = 1'b1;
            dactive = 1'b0;
        end else begin
            if (!dactive) begin
                dactive = 1'b1;
                dwait   = data_waits[dpick];
                dpick   = dpick + 8'd1;
            end
            if (dwait > 0) begin
                ackd_n = 1'b1;
                dwait  = dwait - 1;
            end else begin
                ackd_n  = 1'b0;
                ddt_in  = dmem[dad[7:2]];
                dactive = 1'b0;
            end
        end
    end

    // Store lands at the edge that ends the acknowledged cycle
    always @(negedge clk) begin
        if (mreq && write && !ackd_n) begin
            dmem[dad[7:2]] = ddt_out;
        end
    end

    initial begin
        int n;
        bit seen;
        bit timed_out;

        rst_n   = 1'b0;
        idt     = NOP_WORD;
        acki_n  = 1'b1;
        ddt_in  = 32'h0;
        ackd_n  = 1'b1;
        ipick   = 8'd0;
        dpick   = 8'd0;
        iwait   = 0;
        dwait   = 0;
        dactive = 1'b0;
        cycles  = 0;
        errors  = 0;
        checked = 0;
        timed_out = 1'b0;

        void'($urandom(SEED));
        for (int k = 0; k < 256; k++) begin
            ifetch_waits[k[7:0]] = int'($urandom % 4);
            data_waits[k[7:0]]   = int'($urandom % 4);
        end
        // Fill word holds its own byte address
        for (int k = 0; k < 64; k++) begin
            dmem[k[5:0]]       = 32'hc0de_0000 + 32'(k * 4);
            prog_table[k[5:0]] = NOP_WORD;
        end

        prog_table[0]  = itype(OPI, 0, 1, 0, 5);        // addi x1, x0, 5
        prog_table[1]  = itype(OPI, 0, 2, 0, -3);       // addi x2, x0, -3
        prog_table[2]  = rtype(0, 0, 3, 1, 2);          // add  x3, x1, x2
        prog_table[3]  = stype(3, 0, 'h80);             // sw   x3, 0x80(x0)
        prog_table[4]  = rtype('h20, 0, 4, 2, 1);       // sub  x4, x2, x1
        prog_table[5]  = rtype(0, 2, 5, 2, 1);          // slt  x5, x2, x1
        prog_table[6]  = stype(4, 0, 'h84);             // sw   x4, 0x84(x0)
        prog_table[7]  = stype(5, 0, 'h88);             // sw   x5, 0x88(x0)
        prog_table[8]  = rtype(0, 2, 12, 1, 2);         // slt  x12, x1, x2
        prog_table[9]  = stype(12, 0, 'h8c);            // sw   x12, 0x8c(x0)
        prog_table[10] = itype(OPI, 4, 6, 2, 'h0f0);    // xori x6, x2, 0x0f0
        prog_table[11] = itype(OPI, 6, 7, 1, 'h100);    // ori  x7, x1, 0x100
        prog_table[12] = itype(OPI, 7, 8, 2, 'h7f0);    // andi x8, x2, 0x7f0
        prog_table[13] = rtype(0, 4, 9, 6, 7);          // xor  x9, x6, x7
        prog_table[14] = rtype(0, 7, 10, 6, 8);         // and  x10, x6, x8
        prog_table[15] = rtype(0, 6, 11, 7, 8);         // or   x11, x7, x8
        prog_table[16] = stype(9, 0, 'h90);             // sw   x9, 0x90(x0)
        prog_table[17] = stype(10, 0, 'h94);            // sw   x10, 0x94(x0)
        prog_table[18] = stype(11, 0, 'h98);            // sw   x11, 0x98(x0)
        prog_table[19] = itype(LD, 2, 13, 0, 'h40);     // lw   x13, 0x40(x0)
        prog_table[20] = itype(OPI, 0, 14, 13, 1);      // addi x14, x13, 1
        prog_table[21] = stype(14, 0, 'h9c);            // sw   x14, 0x9c(x0)
        prog_table[22] = itype(LD, 2, 15, 0, 'h80);     // lw   x15, 0x80(x0)
        prog_table[23] = rtype(0, 0, 16, 15, 15);       // add  x16, x15, x15
        prog_table[24] = stype(16, 0, 'ha0);            // sw   x16, 0xa0(x0)
        prog_table[25] = btype(0, 1, 1, 8);             // beq  x1, x1, +8
        prog_table[26] = stype(1, 0, 'hf0);             // sw   x1, 0xf0(x0)
        prog_table[27] = btype(1, 1, 1, 8);             // bne  x1, x1, +8
        prog_table[28] = stype(1, 0, 'ha4);             // sw   x1, 0xa4(x0)
        prog_table[29] = btype(0, 1, 2, 8);             // beq  x1, x2, +8
        prog_table[30] = stype(2, 0, 'ha8);             // sw   x2, 0xa8(x0)
        prog_table[31] = btype(1, 1, 2, 8);             // bne  x1, x2, +8
        prog_table[32] = stype(2, 0, 'hf4);             // sw   x2, 0xf4(x0)
        prog_table[33] = jtype(17, 12);                 // jal  x17, +12
        prog_table[34] = stype(1, 0, 'hf8);             // sw   x1, 0xf8(x0)
        prog_table[35] = stype(1, 0, 'hfc);             // sw   x1, 0xfc(x0)
        prog_table[36] = stype(17, 0, 'hac);            // sw   x17, 0xac(x0)
        prog_table[37] = jtype(0, 0);                   // jal  x0, 0

        store_table[0]  = '{32'h0000_0080, 32'h0000_0002};   // 5 + -3
        store_table[1]  = '{32'h0000_0084, 32'hffff_fff8};   // -3 - 5
        store_table[2]  = '{32'h0000_0088, 32'h0000_0001};   // -3 < 5
        store_table[3]  = '{32'h0000_008c, 32'h0000_0000};   // 5 < -3 false
        store_table[4]  = '{32'h0000_0090, 32'hffff_fe08};
        store_table[5]  = '{32'h0000_0094, 32'h0000_0700};
        store_table[6]  = '{32'h0000_0098, 32'h0000_07f5};
        store_table[7]  = '{32'h0000_009c, 32'hc0de_0041};   // fill at 0x40 plus one
        store_table[8]  = '{32'h0000_00a0, 32'h0000_0004};
        store_table[9]  = '{32'h0000_00a4, 32'h0000_0005};
        store_table[10] = '{32'h0000_00a8, 32'hffff_fffd};
        store_table[11] = '{32'h0000_00ac, 32'h0000_0088};   // link of jal at 0x84

        repeat (15) @(posedge clk);
        @(negedge clk);
        check_idle("during reset");
        @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle("after reset");

        for (n = 0; n < N_STORES && !timed_out; n++) begin
            seen = 1'b0;
            while (!seen && cycles < CYCLE_LIMIT) begin
                @(negedge clk);
                seen = mreq && write && !ackd_n;
            end
            if (!seen) begin
                timed_out = 1'b1;
                errors++;
                $display("Timeout after %0d cycles while waiting for store %0d to address %h",
                         cycles, n, store_table[n].addr);
            end else begin
                checked++;
                if (dad !== store_table[n].addr || ddt_out !== store_table[n].data) begin
                    errors++;
                    $display("ERR %0t: store %0d wrote %h to %h, expected %h to %h", $time,
                             n, ddt_out, dad, store_table[n].data, store_table[n].addr);
                end
            end
        end

        // Program now spins on its last jump, so any further store is extra
        if (!timed_out) begin
            repeat (TAIL_CYCLES) begin
                @(negedge clk);
                if (mreq && write && !ackd_n) begin
                    errors++;
                    $display("ERR %0t: unexpected store of %h to %h", $time, ddt_out, dad);
                end
            end
        end

        $display("Stores checked %0d of %0d, errors %0d", checked, N_STORES, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== list.f ====
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_regfile.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_mem_wb.sv
rv_hazard.sv
rv_core.sv
tb_clk_gen.sv
tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       ?= tb_rv_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
